// ==== axiMem_defs.svh ====
`ifndef AXIMEM_DEFS_SVH
`define AXIMEM_DEFS_SVH

// ------------------------------
// AXI field widths
// ------------------------------
`define AXI_ID_W     4
`define AXI_ADDR_W   32
`define AXI_DATA_W   32
`define AXI_STRB_W   4   // one strobe bit per data byte
`define AXI_LEN_W    8

// ------------------------------
// memory and read path sizing
// ------------------------------
`define MEM_ADDR_BITS  12  // 4 KB of byte address space
`define RD_QUEUE_DEPTH 2

`endif

// ==== axiMemPkg.sv ====
`include "axiMem_defs.svh"

package axiMemPkg;

  typedef logic [`AXI_ID_W-1:0]      idT;
  typedef logic [`MEM_ADDR_BITS-1:0] memAddrT;
  typedef logic [`AXI_DATA_W-1:0]    dataT;
  typedef logic [`AXI_STRB_W-1:0]    strbT;
  typedef logic [`AXI_LEN_W-1:0]     lenT;  // beats minus one
  typedef logic [2:0]                sizeT; // log2 of bytes per beat

  typedef enum logic [1:0] {FIXED = 2'b00, INCR = 2'b01, WRAP = 2'b10, RESERVED = 2'b11} burstT;
  typedef enum logic [1:0] {OKAY = 2'b00, SLVERR = 2'b10} respT;

  typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wrStateT;
  typedef enum logic [1:0] {RD_IDLE, RD_ISSUE, RD_DRAIN} rdStateT;

  // address of the next beat in a burst
  // WRAP is not supported and holds the address like FIXED
  function automatic memAddrT nextAddr(memAddrT addr, sizeT size, burstT burst);
    memAddrT result;
    result = addr;
    if (burst == INCR) begin
      if ((32'd1 << size) < `AXI_STRB_W) begin
        result = addr + (memAddrT'(1) << size); // narrow beat
      end else begin
        result = (addr | memAddrT'(`AXI_STRB_W - 1)) + memAddrT'(1); // next aligned word
      end
    end
    return result; // wraps inside the 4 KB space
  endfunction

endpackage

// ==== axiMemIfs.sv ====
`timescale 1ns/1ps

// ------------------------------
// write port of the memory
// ------------------------------
interface memWrIf;
  logic               en;   // write on every edge where high
  axiMemPkg::memAddrT addr;
  axiMemPkg::dataT    data;
  axiMemPkg::strbT    strb;

  modport ctrl (output en, output addr, output data, output strb);
  modport mem  (input en, input addr, input data, input strb);
endinterface

// ------------------------------
// read request path
// ------------------------------
interface rdReqIf;
  logic               en;
  axiMemPkg::memAddrT addr;
  logic               last;  // final beat of the burst
  axiMemPkg::idT      id;
  logic               ready; // request taken when en && ready
  axiMemPkg::dataT    data;  // word for the request of the previous edge

  modport req  (output en, output addr, output last, output id, input ready);
  modport mem  (input en, input addr, input ready, output data);
  modport resp (input en, input last, input id, input data, output ready);
endinterface

// ==== memArray.sv ====
`timescale 1ns/1ps
`include "axiMem_defs.svh"

module memArray (
  input  logic ACLK,
  memWrIf.mem  memWr,
  rdReqIf.mem  rdReq
);

  localparam int wordLsb = $clog2(`AXI_STRB_W);
  localparam int depth   = 2 ** (`MEM_ADDR_BITS - wordLsb);

  axiMemPkg::dataT mem [depth];

  logic [`MEM_ADDR_BITS-wordLsb-1:0] wrWord;
  logic [`MEM_ADDR_BITS-wordLsb-1:0] rdWord;

  assign wrWord = memWr.addr[`MEM_ADDR_BITS-1:wordLsb];
  assign rdWord = rdReq.addr[`MEM_ADDR_BITS-1:wordLsb];

  // byte lanes enabled by strobe
  always_ff @(posedge ACLK) begin
    if (memWr.en) begin
      for (int i = 0; i < `AXI_STRB_W; i++) begin
        if (memWr.strb[i]) begin
          mem[wrWord][8*i +: 8] <= memWr.data[8*i +: 8];
        end
      end
    end
  end

  // registered read returns old data on a same-cycle collision
  always_ff @(posedge ACLK) begin
    if (rdReq.en && rdReq.ready) begin
      rdReq.data <= mem[rdWord];
    end
  end

endmodule

// ==== axiWriteCtrl.sv ====
`timescale 1ns/1ps

module axiWriteCtrl (
  input  logic                ACLK,
  input  logic                ARESETn,
  input  axiMemPkg::idT       AWID,
  input  axiMemPkg::memAddrT  AWADDR,
  input  axiMemPkg::lenT      AWLEN,
  input  axiMemPkg::sizeT     AWSIZE,
  input  axiMemPkg::burstT    AWBURST,
  input  logic                AWVALID,
  output logic                AWREADY,
  input  axiMemPkg::dataT     WDATA,
  input  axiMemPkg::strbT     WSTRB,
  input  logic                WLAST,
  input  logic                WVALID,
  output logic                WREADY,
  output axiMemPkg::idT       BID,
  output axiMemPkg::respT     BRESP,
  output logic                BVALID,
  input  logic                BREADY,
  memWrIf.ctrl                memWr
);

  axiMemPkg::wrStateT state;
  axiMemPkg::memAddrT addrReg; // address of the next beat
  axiMemPkg::lenT     lenReg;
  axiMemPkg::sizeT    sizeReg;
  axiMemPkg::burstT   burstReg;
  axiMemPkg::lenT     beatCnt;

  logic awHs;
  logic wHs;
  logic finalBeat;

  assign AWREADY   = (state == axiMemPkg::WR_IDLE);
  assign WREADY    = (state == axiMemPkg::WR_DATA);
  assign BVALID    = (state == axiMemPkg::WR_RESP);
  assign awHs      = AWVALID & AWREADY;
  assign wHs       = WVALID & WREADY;
  assign finalBeat = (beatCnt == lenReg); // set by the beat count alone

  // ------------------------------
  // control
  // ------------------------------
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      state    <= axiMemPkg::WR_IDLE;
      beatCnt  <= '0;
      memWr.en <= 1'b0;
    end else begin
      memWr.en <= wHs; // memory write one edge after the beat
      case (state)
        axiMemPkg::WR_IDLE: begin
          beatCnt <= '0;
          if (awHs) state <= axiMemPkg::WR_DATA;
        end
        axiMemPkg::WR_DATA: begin
          if (wHs) begin
            beatCnt <= beatCnt + 1'b1;
            if (finalBeat) state <= axiMemPkg::WR_RESP;
          end
        end
        axiMemPkg::WR_RESP: if (BREADY) state <= axiMemPkg::WR_IDLE;
        default: state <= axiMemPkg::WR_IDLE;
      endcase
    end
  end

  // ------------------------------
  // burst and beat payload
  // ------------------------------
  always_ff @(posedge ACLK) begin
    if (awHs) begin
      addrReg  <= AWADDR;
      lenReg   <= AWLEN;
      sizeReg  <= AWSIZE;
      burstReg <= AWBURST;
      BID      <= AWID;
    end
    if (wHs) begin
      memWr.addr <= addrReg;
      memWr.data <= WDATA;
      memWr.strb <= WSTRB;
      addrReg    <= axiMemPkg::nextAddr(addrReg, sizeReg, burstReg);
      if (finalBeat) begin
        BRESP <= WLAST ? axiMemPkg::OKAY : axiMemPkg::SLVERR; // missing WLAST
      end
    end
  end

endmodule

// ==== axiReadCtrl.sv ====
`timescale 1ns/1ps

module axiReadCtrl (
  input  logic                ACLK,
  input  logic                ARESETn,
  input  axiMemPkg::idT       ARID,
  input  axiMemPkg::memAddrT  ARADDR,
  input  axiMemPkg::lenT      ARLEN,
  input  axiMemPkg::sizeT     ARSIZE,
  input  axiMemPkg::burstT    ARBURST,
  input  logic                ARVALID,
  output logic                ARREADY,
  input  logic                burstDone, // final beat has left on R
  rdReqIf.req                 rdReq
);

  axiMemPkg::rdStateT state;
  axiMemPkg::memAddrT addrReg;
  axiMemPkg::lenT     lenReg;
  axiMemPkg::sizeT    sizeReg;
  axiMemPkg::burstT   burstReg;
  axiMemPkg::idT      idReg;
  axiMemPkg::lenT     beatCnt; // beats issued so far

  logic arHs;
  logic accept;

  assign ARREADY    = (state == axiMemPkg::RD_IDLE);
  assign arHs       = ARVALID & ARREADY;
  assign accept     = rdReq.en & rdReq.ready;
  assign rdReq.en   = (state == axiMemPkg::RD_ISSUE);
  assign rdReq.addr = addrReg;
  assign rdReq.id   = idReg;
  assign rdReq.last = (beatCnt == lenReg);

  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      state   <= axiMemPkg::RD_IDLE;
      beatCnt <= '0;
    end else begin
      case (state)
        axiMemPkg::RD_IDLE: begin
          beatCnt <= '0;
          if (arHs) state <= axiMemPkg::RD_ISSUE;
        end
        axiMemPkg::RD_ISSUE: begin
          if (accept) begin
            beatCnt <= beatCnt + 1'b1;
            if (rdReq.last) state <= axiMemPkg::RD_DRAIN;
          end
        end
        axiMemPkg::RD_DRAIN: if (burstDone) state <= axiMemPkg::RD_IDLE;
        default: state <= axiMemPkg::RD_IDLE;
      endcase
    end
  end

  // burst fields and address stepping
  always_ff @(posedge ACLK) begin
    if (arHs) begin
      addrReg  <= ARADDR;
      lenReg   <= ARLEN;
      sizeReg  <= ARSIZE;
      burstReg <= ARBURST;
      idReg    <= ARID;
    end else if (accept) begin
      addrReg <= axiMemPkg::nextAddr(addrReg, sizeReg, burstReg);
    end
  end

endmodule

// ==== readResponse.sv ====
`timescale 1ns/1ps
`include "axiMem_defs.svh"

module readResponse (
  input  logic             ACLK,
  input  logic             ARESETn,
  rdReqIf.resp             rdReq,
  output axiMemPkg::idT    RID,
  output axiMemPkg::dataT  RDATA,
  output axiMemPkg::respT  RRESP,
  output logic             RLAST,
  output logic             RVALID,
  input  logic             RREADY,
  output logic             burstDone
);

  localparam int depth = `RD_QUEUE_DEPTH;
  localparam int ptrW  = (depth > 1) ? $clog2(depth) : 1;
  localparam int cntW  = $clog2(depth + 1);

  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [cntW-1:0] count;
  logic            inFlight; // memory read issued last edge
  axiMemPkg::idT   tagId;
  logic            tagLast;
  axiMemPkg::idT   qId   [depth];
  logic            qLast [depth];
  axiMemPkg::dataT qData [depth];
  logic            pop;

  assign pop    = RVALID & RREADY;
  assign RVALID = (count != '0);
  assign RID    = qId[rdPtr];
  assign RDATA  = qData[rdPtr];
  assign RLAST  = qLast[rdPtr];
  assign RRESP  = axiMemPkg::OKAY;
  assign burstDone = pop & RLAST;
  // room for the beat in flight plus a new one
  assign rdReq.ready = (int'(count) + int'(inFlight) - int'(pop)) < depth;

  // ------------------------------
  // queue control
  // ------------------------------
  always_ff @(posedge ACLK or negedge ARESETn) begin
    if (!ARESETn) begin
      inFlight <= 1'b0;
      wrPtr    <= '0;
      rdPtr    <= '0;
      count    <= '0;
    end else begin
      inFlight <= rdReq.en & rdReq.ready;
      if (inFlight) wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + 1'b1;
      if (pop) rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + 1'b1;
      count <= count + cntW'(inFlight) - cntW'(pop);
    end
  end

  // tag capture and queue storage
  always_ff @(posedge ACLK) begin
    if (rdReq.en && rdReq.ready) begin
      tagId   <= rdReq.id;
      tagLast <= rdReq.last;
    end
    if (inFlight) begin
      qId[wrPtr]   <= tagId;
      qLast[wrPtr] <= tagLast;
      qData[wrPtr] <= rdReq.data;
    end
  end

endmodule

// ==== axiMemTop.sv ====
`timescale 1ns/1ps
`include "axiMem_defs.svh"

module axiMemTop (
  input  logic                   ACLK,
  input  logic                   ARESETn,
  // write address
  input  axiMemPkg::idT          AWID,
  input  logic [`AXI_ADDR_W-1:0] AWADDR,
  input  axiMemPkg::lenT         AWLEN,
  input  axiMemPkg::sizeT        AWSIZE,
  input  axiMemPkg::burstT       AWBURST,
  input  logic                   AWVALID,
  output logic                   AWREADY,
  // write data and response
  input  axiMemPkg::dataT        WDATA,
  input  axiMemPkg::strbT        WSTRB,
  input  logic                   WLAST,
  input  logic                   WVALID,
  output logic                   WREADY,
  output axiMemPkg::idT          BID,
  output axiMemPkg::respT        BRESP,
  output logic                   BVALID,
  input  logic                   BREADY,
  // read address
  input  axiMemPkg::idT          ARID,
  input  logic [`AXI_ADDR_W-1:0] ARADDR,
  input  axiMemPkg::lenT         ARLEN,
  input  axiMemPkg::sizeT        ARSIZE,
  input  axiMemPkg::burstT       ARBURST,
  input  logic                   ARVALID,
  output logic                   ARREADY,
  // read data
  output axiMemPkg::idT          RID,
  output axiMemPkg::dataT        RDATA,
  output axiMemPkg::respT        RRESP,
  output logic                   RLAST,
  output logic                   RVALID,
  input  logic                   RREADY
);

  memWrIf memWr ();
  rdReqIf rdReq ();

  logic burstDone;

  axiWriteCtrl uWrite (
    .ACLK, .ARESETn,
    .AWID, .AWADDR(AWADDR[`MEM_ADDR_BITS-1:0]), .AWLEN, .AWSIZE, .AWBURST,
    .AWVALID, .AWREADY,
    .WDATA, .WSTRB, .WLAST, .WVALID, .WREADY,
    .BID, .BRESP, .BVALID, .BREADY,
    .memWr(memWr.ctrl)
  );

  axiReadCtrl uRead (
    .ACLK, .ARESETn,
    .ARID, .ARADDR(ARADDR[`MEM_ADDR_BITS-1:0]), .ARLEN, .ARSIZE, .ARBURST,
    .ARVALID, .ARREADY,
    .burstDone,
    .rdReq(rdReq.req)
  );

  memArray uMem (
    .ACLK,
    .memWr(memWr.mem),
    .rdReq(rdReq.mem)
  );

  readResponse uResp (
    .ACLK, .ARESETn,
    .rdReq(rdReq.resp),
    .RID, .RDATA, .RRESP, .RLAST, .RVALID, .RREADY,
    .burstDone
  );

endmodule

// ==== axiMem_asserts.sv ====
`timescale 1ns/1ps

module axiMemAsserts (
  input logic              ACLK,
  input logic              ARESETn,
  input logic              AWREADY,
  input logic              WREADY,
  input logic              BVALID,
  input logic              BREADY,
  input axiMemPkg::idT     BID,
  input axiMemPkg::respT   BRESP,
  input logic              RVALID,
  input logic              RREADY,
  input axiMemPkg::idT     RID,
  input axiMemPkg::dataT   RDATA,
  input logic              RLAST
);

  // ------------------------------
  // valid holds until ready
  // ------------------------------
  bHoldA: assert property (@(posedge ACLK) disable iff (!ARESETn)
    BVALID && !BREADY |=> BVALID && $stable(BID) && $stable(BRESP))
    else $error("B channel changed while waiting for BREADY");

  rHoldA: assert property (@(posedge ACLK) disable iff (!ARESETn)
    RVALID && !RREADY |=> RVALID && $stable(RDATA) && $stable(RLAST) && $stable(RID))
    else $error("R channel changed while waiting for RREADY");

  // no responses while in reset
  resetQuietA: assert property (@(posedge ACLK) !ARESETn |-> !BVALID && !RVALID)
    else $error("BVALID or RVALID high during reset");

  awWExclusiveA: assert property (@(posedge ACLK) disable iff (!ARESETn)
    !(AWREADY && WREADY))
    else $error("AWREADY and WREADY high in the same cycle");

endmodule

// ==== tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
  output logic ACLK,
  output logic ARESETn
);

  localparam int halfPeriod = 2; // 4 ns clock
  localparam int resetCycles = 8;

  initial begin
    ACLK = 1'b0;
    forever #halfPeriod ACLK = ~ACLK;
  end

  // async reset falls before the first rising edge
  initial begin
    ARESETn = 1'b1;
    #1 ARESETn = 1'b0;
    repeat (resetCycles) @(posedge ACLK);
    @(negedge ACLK);
    ARESETn = 1'b1; // released away from the active edge
  end

endmodule

// ==== axiMemTb.sv ====
`timescale 1ns/1ps
`include "axiMem_defs.svh"

module axiMemTb;

  localparam int timeoutCycles = 200;
  localparam int memBytes      = 2 ** `MEM_ADDR_BITS;
  localparam int wordBytes     = `AXI_STRB_W;

  logic                   ACLK;
  logic                   ARESETn;
  axiMemPkg::idT          AWID;
  logic [`AXI_ADDR_W-1:0] AWADDR;
  axiMemPkg::lenT         AWLEN;
  axiMemPkg::sizeT        AWSIZE;
  axiMemPkg::burstT       AWBURST;
  logic                   AWVALID;
  logic                   AWREADY;
  axiMemPkg::dataT        WDATA;
  axiMemPkg::strbT        WSTRB;
  logic                   WLAST;
  logic                   WVALID;
  logic                   WREADY;
  axiMemPkg::idT          BID;
  axiMemPkg::respT        BRESP;
  logic                   BVALID;
  logic                   BREADY;
  axiMemPkg::idT          ARID;
  logic [`AXI_ADDR_W-1:0] ARADDR;
  axiMemPkg::lenT         ARLEN;
  axiMemPkg::sizeT        ARSIZE;
  axiMemPkg::burstT       ARBURST;
  logic                   ARVALID;
  logic                   ARREADY;
  axiMemPkg::idT          RID;
  axiMemPkg::dataT        RDATA;
  axiMemPkg::respT        RRESP;
  logic                   RLAST;
  logic                   RVALID;
  logic                   RREADY;

  logic [7:0]  shadowMem [memBytes]; // expected memory bytes
  bit          known     [memBytes]; // byte written at least once
  logic [31:0] lcgState;
  int          dataErrors;
  int          respErrors;
  int          idErrors;
  int          flagErrors;
  int          otherErrors;
  bit          abortRun; // set by a timeout to stop further stimulus

  tbClock clockGen (.ACLK(ACLK), .ARESETn(ARESETn));

  axiMemTop dut (.*);

  bind axiMemTop axiMemAsserts asserts (
    .ACLK(ACLK), .ARESETn(ARESETn), .AWREADY(AWREADY), .WREADY(WREADY),
    .BVALID(BVALID), .BREADY(BREADY), .BID(BID), .BRESP(BRESP),
    .RVALID(RVALID), .RREADY(RREADY), .RID(RID), .RDATA(RDATA), .RLAST(RLAST)
  );

  // ------------------------------
  // helpers
  // ------------------------------
  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1103515245 + 32'd12345;
    return lcgState;
  endfunction

  function automatic logic pickReady(bit stall);
    logic [31:0] r;
    if (!stall) return 1'b1;
    r = nextRandom();
    return r[16]; // upper bits are less periodic
  endfunction

  // INCR steps by the beat size and full beats land on the next word
  function automatic axiMemPkg::memAddrT stepAddr(axiMemPkg::memAddrT a, axiMemPkg::sizeT size,
                                                  axiMemPkg::burstT burst);
    int bytes;
    int next;
    bytes = 1 << size;
    next  = int'(a);
    if (burst == axiMemPkg::INCR) begin
      if (bytes < wordBytes) next = next + bytes;
      else next = (next / wordBytes) * wordBytes + wordBytes;
    end
    return axiMemPkg::memAddrT'(next % memBytes);
  endfunction

  // mask moved into the lane of a narrow beat
  function automatic axiMemPkg::strbT laneStrobe(axiMemPkg::memAddrT a, axiMemPkg::sizeT size,
                                                 axiMemPkg::strbT mask);
    int bytes;
    int lane;
    axiMemPkg::strbT low;
    bytes = 1 << size;
    if (bytes >= wordBytes) return mask;
    lane = ((int'(a) % wordBytes) / bytes) * bytes;
    low  = axiMemPkg::strbT'((1 << bytes) - 1);
    return axiMemPkg::strbT'((mask & low) << lane);
  endfunction

  task automatic writeShadow(axiMemPkg::memAddrT a, axiMemPkg::dataT data, axiMemPkg::strbT strb);
    int base;
    base = (int'(a) / wordBytes) * wordBytes;
    for (int i = 0; i < wordBytes; i++) begin
      if (strb[i]) begin
        shadowMem[base + i] = data[8*i +: 8];
        known[base + i]     = 1'b1;
      end
    end
  endtask

  task automatic expectedWord(input axiMemPkg::memAddrT a, output axiMemPkg::dataT exp,
                              output axiMemPkg::dataT mask);
    int base;
    base = (int'(a) / wordBytes) * wordBytes;
    exp  = '0;
    mask = '0;
    for (int i = 0; i < wordBytes; i++) begin
      if (known[base + i]) begin
        exp[8*i +: 8]  = shadowMem[base + i];
        mask[8*i +: 8] = 8'hff; // unwritten bytes are not compared
      end
    end
  endtask

  task automatic waitCycle(inout int cnt, input string what);
    if (cnt >= timeoutCycles) begin
      $display("timeout: no %s within %0d cycles", what, timeoutCycles);
      otherErrors++;
      abortRun = 1'b1;
    end else begin
      @(negedge ACLK);
      cnt++;
    end
  endtask

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic checkData(string name, axiMemPkg::dataT got, axiMemPkg::dataT exp,
                           axiMemPkg::dataT mask);
    if ((got & mask) !== (exp & mask)) begin
      $display("[ERROR] %s got 0x%h expected 0x%h byte mask 0x%h", name, got, exp, mask);
      dataErrors++;
    end
  endtask

  task automatic checkResp(string name, axiMemPkg::respT got, axiMemPkg::respT exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
      respErrors++;
    end
  endtask

  task automatic checkId(string name, axiMemPkg::idT got, axiMemPkg::idT exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
      idErrors++;
    end
  endtask

  task automatic checkFlag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("[ERROR] %s got 0x%h expected 0x%h", name, got, exp);
      flagErrors++;
    end
  endtask

  // ------------------------------
  // bus transactions
  // ------------------------------
  task automatic writeBurst(axiMemPkg::idT id, axiMemPkg::memAddrT addr, axiMemPkg::lenT len,
                            axiMemPkg::sizeT size, axiMemPkg::burstT burst,
                            axiMemPkg::strbT mask, bit omitLast);
    int                 cnt;
    bit                 stall;
    axiMemPkg::memAddrT beatAddr;
    axiMemPkg::strbT    strb;
    axiMemPkg::dataT    data;
    stall    = (len >= 3);
    beatAddr = addr;
    AWID     = id;
    AWADDR   = `AXI_ADDR_W'(addr);
    AWLEN    = len;
    AWSIZE   = size;
    AWBURST  = burst;
    AWVALID  = 1'b1;
    cnt = 0;
    while (!AWREADY && !abortRun) waitCycle(cnt, "AWREADY");
    @(negedge ACLK);
    AWVALID = 1'b0;
    for (int beat = 0; beat <= int'(len) && !abortRun; beat++) begin
      data   = nextRandom();
      strb   = laneStrobe(beatAddr, size, mask);
      WDATA  = data;
      WSTRB  = strb;
      WLAST  = (beat == int'(len)) && !omitLast;
      WVALID = 1'b1;
      cnt = 0;
      while (!WREADY && !abortRun) waitCycle(cnt, "WREADY");
      writeShadow(beatAddr, data, strb);
      beatAddr = stepAddr(beatAddr, size, burst);
      @(negedge ACLK);
    end
    WVALID = 1'b0;
    WLAST  = 1'b0;
    cnt    = 0;
    BREADY = pickReady(stall);
    while (!(BVALID && BREADY) && !abortRun) begin
      waitCycle(cnt, "B handshake");
      BREADY = pickReady(stall);
    end
    if (!abortRun) begin
      checkId("BID", BID, id);
      checkResp("BRESP", BRESP, omitLast ? axiMemPkg::SLVERR : axiMemPkg::OKAY);
    end
    @(negedge ACLK);
    BREADY = 1'b0;
  endtask

  task automatic readBurst(axiMemPkg::idT id, axiMemPkg::memAddrT addr, axiMemPkg::lenT len,
                           axiMemPkg::sizeT size, axiMemPkg::burstT burst);
    int                 cnt;
    bit                 stall;
    axiMemPkg::memAddrT beatAddr;
    axiMemPkg::dataT    exp;
    axiMemPkg::dataT    mask;
    stall    = (len >= 3); // longer bursts see RREADY back-pressure
    beatAddr = addr;
    ARID     = id;
    ARADDR   = `AXI_ADDR_W'(addr);
    ARLEN    = len;
    ARSIZE   = size;
    ARBURST  = burst;
    ARVALID  = 1'b1;
    cnt = 0;
    while (!ARREADY && !abortRun) waitCycle(cnt, "ARREADY");
    @(negedge ACLK);
    ARVALID = 1'b0;
    for (int beat = 0; beat <= int'(len) && !abortRun; beat++) begin
      cnt    = 0;
      RREADY = pickReady(stall);
      while (!(RVALID && RREADY) && !abortRun) begin
        waitCycle(cnt, "R handshake");
        RREADY = pickReady(stall);
      end
      if (!abortRun) begin
        expectedWord(beatAddr, exp, mask);
        checkData("RDATA", RDATA, exp, mask);
        checkId("RID", RID, id);
        checkResp("RRESP", RRESP, axiMemPkg::OKAY);
        checkFlag("RLAST", RLAST, beat == int'(len));
      end
      beatAddr = stepAddr(beatAddr, size, burst);
      @(negedge ACLK);
    end
    RREADY = 1'b0;
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    int          fd;
    int          got;
    int          fields;
    int          txnCnt;
    int          cnt;
    string       line;
    logic [7:0]  op;
    logic [31:0] col [7];
    lcgState    = 32'd59;
    dataErrors  = 0;
    respErrors  = 0;
    idErrors    = 0;
    flagErrors  = 0;
    otherErrors = 0;
    abortRun    = 1'b0;
    txnCnt      = 0;
    AWID    = '0;
    AWADDR  = '0;
    AWLEN   = '0;
    AWSIZE  = '0;
    AWBURST = axiMemPkg::INCR;
    AWVALID = 1'b0;
    WDATA   = '0;
    WSTRB   = '0;
    WLAST   = 1'b0;
    WVALID  = 1'b0;
    BREADY  = 1'b0;
    ARID    = '0;
    ARADDR  = '0;
    ARLEN   = '0;
    ARSIZE  = '0;
    ARBURST = axiMemPkg::INCR;
    ARVALID = 1'b0;
    RREADY  = 1'b0;

    cnt = 0;
    @(negedge ACLK);
    while (ARESETn !== 1'b1 && !abortRun) waitCycle(cnt, "reset release");
    checkFlag("BVALID", BVALID, 1'b0);
    checkFlag("RVALID", RVALID, 1'b0);
    cnt = 0;
    while (!(AWREADY && ARREADY) && !abortRun) waitCycle(cnt, "AWREADY and ARREADY after reset");

    fd = $fopen("axiMem_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file axiMem_testdata.txt");
      otherErrors++;
    end else begin
      while (!$feof(fd) && !abortRun) begin
        line   = "";
        fields = 0;
        got    = $fgets(line, fd);
        if (got > 0) begin
          fields = $sscanf(line, "%s %h %h %h %h %h %h %h", op, col[0], col[1], col[2],
                           col[3], col[4], col[5], col[6]);
        end
        if (fields == 8 && op == "W") begin
          writeBurst(axiMemPkg::idT'(col[0]), axiMemPkg::memAddrT'(col[1]),
                     axiMemPkg::lenT'(col[2]), axiMemPkg::sizeT'(col[3]),
                     axiMemPkg::burstT'(col[4][1:0]), axiMemPkg::strbT'(col[5]), col[6][0]);
          txnCnt++;
        end else if (fields == 8 && op == "R") begin
          readBurst(axiMemPkg::idT'(col[0]), axiMemPkg::memAddrT'(col[1]),
                    axiMemPkg::lenT'(col[2]), axiMemPkg::sizeT'(col[3]),
                    axiMemPkg::burstT'(col[4][1:0]));
          txnCnt++;
        end
      end
      $fclose(fd);
      if (txnCnt == 0) begin
        $display("no transactions found in axiMem_testdata.txt");
        otherErrors++;
      end
    end

    $display("errors: %0d data, %0d response, %0d id, %0d flag, %0d other",
             dataErrors, respErrors, idErrors, flagErrors, otherErrors);
    if (dataErrors + respErrors + idErrors + flagErrors + otherErrors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== axiMem_testdata.txt ====
# op id addr len size burst strobe omitLast, numbers in hex
# op W is a write and R a read, burst 0 is FIXED and 1 is INCR, reads ignore the last two
W 1 100 0 2 1 f 0
W 2 100 0 2 1 6 0
R 3 100 0 2 1 0 0
W 4 200 7 2 1 f 0
R 5 200 0 2 1 0 0
R 6 204 1 2 1 0 0
R 7 200 2 2 1 0 0
R 8 208 3 2 1 0 0
R 9 200 4 2 1 0 0
R a 200 5 2 1 0 0
R b 200 6 2 1 0 0
R c 200 7 2 1 0 0
W d 300 3 2 0 f 0
R e 300 3 2 0 0 0
W f 401 5 0 1 1 0
R 1 400 1 2 1 0 0
W 2 500 5 2 1 f 1
R 3 500 5 2 1 0 0

// ==== list.f ====
+incdir+.
axiMemPkg.sv
axiMemIfs.sv
memArray.sv
axiWriteCtrl.sv
axiReadCtrl.sv
readResponse.sv
axiMemTop.sv
axiMem_asserts.sv
tbClock.sv
axiMemTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the AXI memory testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module axiMemTb -f list.f

./obj_dir/VaxiMemTb > sim.log 2>&1
cat sim.log

if grep -q "Testbench failed" sim.log; then
  exit 1
fi
exit 0
